// File: ex1IsaPkg.sv
// ISA definitions for the first execute stage: micro-ops, sub-ops, conditions, register IDs
`default_nettype none

package ex1IsaPkg;

	// field widths of the decoded op
	localparam int unsigned UCMD_W = 6;
	localparam int unsigned IXT_W = 6;
	localparam int unsigned COND_W = 2;
	localparam int unsigned REGID_W = 6;

	// one ID space for GPRs and CRs
	typedef logic [REGID_W-1:0] regIdT;

	// opUCmd[5:0]
	typedef enum logic [UCMD_W-1:0] {
		UCMD_NOP = 6'h00,
		UCMD_INVOP,
		UCMD_LEA_MR,
		UCMD_MOV_RM,
		UCMD_MOV_MR,
		UCMD_MOV_RC,
		UCMD_MOV_CR,
		UCMD_MOV_IR,
		UCMD_BRA_NB,
		UCMD_BRA,
		UCMD_BSR,
		UCMD_JMP,
		UCMD_JSR,
		UCMD_ALU3,
		UCMD_MUL3,
		UCMD_OP_IXS,
		UCMD_OP_IXT
	} uCmdE;

	// opUCmd[7:6]
	typedef enum logic [COND_W-1:0] {
		COND_AL = 2'b00,
		COND_NV = 2'b01,
		COND_CT = 2'b10,
		COND_CF = 2'b11
	} condE;

	// sub-ops in opUIxt[5:0]
	typedef enum logic [IXT_W-1:0] {
		IXS_NOP = 6'h00,
		IXS_MOVT,
		IXS_MOVNT,
		IXS_TRAPB
	} ixsE;

	typedef enum logic [IXT_W-1:0] {
		IXT_NOP = 6'h00,
		IXT_SLEEP,
		IXT_BREAK,
		IXT_CLRT,
		IXT_SETT,
		IXT_CLRS,
		IXT_SETS,
		IXT_NOTT,
		IXT_NOTS,
		IXT_RTE,
		IXT_TRAPA,
		IXT_SYSE
	} ixtE;

	// MOV_IR form in opUIxt[3:0]
	typedef enum logic [3:0] {
		MOVIR_LDI = 4'h0,
		MOVIR_LDISH8,
		MOVIR_LDISH16,
		MOVIR_LDISH32,
		MOVIR_JLDIX
	} movIrE;

	// fixed register IDs
	localparam regIdT REG_ZZR = 6'h3F;
	localparam regIdT REG_LR = 6'h1E;
	localparam regIdT REG_DHR = 6'h01;
	localparam regIdT CREG_PC = 6'h00;

endpackage

`default_nettype wire

// File: ex1MachPkg.sv
// machine definitions: data widths, memory bus encodings, SR bits and trap codes
`default_nettype none

package ex1MachPkg;

	localparam int unsigned XLEN = 64;
	localparam int unsigned VALEN = 48;

	// bus op, low 3 bits of LOAD and STORE carry {ixt[2], ixt[5:4]}
	typedef enum logic [4:0] {
		OPM_READY = 5'b00000,
		OPM_LOAD = 5'b01000,
		OPM_STORE = 5'b10000,
		OPM_TRAP = 5'b11000
	} memOpmE;

	// memory reply
	typedef enum logic [1:0] {
		MOK_READY = 2'b00,
		MOK_OK = 2'b01,
		MOK_HOLD = 2'b10
	} memOkE;

	// SR bit positions
	localparam int unsigned SR_T = 0;
	localparam int unsigned SR_S = 1;
	localparam int unsigned SR_JQ = 31;

	// trap codes, low bits filled per op
	localparam logic [15:0] TRAP_RTE = 16'hFF00;
	localparam logic [11:0] TRAP_TRAPA_BASE = 12'hC08;
	localparam logic [3:0] TRAP_SYSE_BASE = 4'hE;

endpackage

`default_nettype wire

// File: ex1CmdIf.sv
// effective command bus from the predicate stage to the execution units
`default_nettype none

interface ex1CmdIf;

	// command after predication
	ex1IsaPkg::uCmdE cmd;
	// sub-op or size field
	logic [ex1IsaPkg::IXT_W-1:0] ixt;
	// destination / immediate register ID
	ex1IsaPkg::regIdT idRm;
	// branch flush from the front end
	logic flush;

	modport source (output cmd, ixt, idRm, flush);
	modport sink (input cmd, ixt, idRm, flush);

endinterface

`default_nettype wire

// File: ex1Predicate.sv
// predicate stage: applies the condition code and flush, drives the effective command
`default_nettype none

module ex1Predicate (
	input logic [8:0] opUCmd,
	input logic [ex1IsaPkg::IXT_W-1:0] opUIxt,
	input ex1IsaPkg::regIdT regIdRm,
	input logic opBraFlush,
	input logic srT,
	ex1CmdIf.source cmdBus,
	output logic [8:0] opUCmdOut
);

	ex1IsaPkg::condE cond;
	ex1IsaPkg::uCmdE rawCmd;
	ex1IsaPkg::uCmdE effCmd;
	logic opEnable;

	assign cond = ex1IsaPkg::condE'(opUCmd[7:6]);
	assign rawCmd = ex1IsaPkg::uCmdE'(opUCmd[5:0]);

	// enable table, flush wins over everything
	always_comb begin
		case (cond)
			ex1IsaPkg::COND_AL: opEnable = 1'b1;
			ex1IsaPkg::COND_NV: opEnable = 1'b0;
			ex1IsaPkg::COND_CT: opEnable = srT;
			default: opEnable = !srT;
		endcase
		if (opBraFlush) begin
			opEnable = 1'b0;
		end
	end

	// disabled BRA still needs resolving against the prediction
	always_comb begin
		effCmd = rawCmd;
		if (!opEnable) begin
			if ((rawCmd == ex1IsaPkg::UCMD_BRA) && !opBraFlush) begin
				effCmd = ex1IsaPkg::UCMD_BRA_NB;
			end else begin
				effCmd = ex1IsaPkg::UCMD_NOP;
			end
		end
	end

	assign cmdBus.cmd = effCmd;
	assign cmdBus.ixt = opUIxt;
	assign cmdBus.idRm = regIdRm;
	assign cmdBus.flush = opBraFlush;

	// later stages see an unconditional op, bit 8 reserved
	assign opUCmdOut = {1'b0, ex1IsaPkg::COND_AL, effCmd};

endmodule

`default_nettype wire

// File: ex1Agu.sv
// address generation: memory address, PC-relative branch target and jump-quadrant flag
`default_nettype none

module ex1Agu (
	input logic clock,
	input logic arstN,
	ex1CmdIf.sink cmdBus,
	input logic [ex1MachPkg::XLEN-1:0] regValRs,
	input logic [ex1MachPkg::XLEN-1:0] regValRt,
	input logic [ex1MachPkg::XLEN-1:0] regValPc,
	input logic srJq,
	output logic [ex1MachPkg::VALEN-1:0] memAddr,
	output logic [ex1MachPkg::VALEN-1:0] braTarget
);

	localparam int unsigned VA = ex1MachPkg::VALEN;

	logic jqFlag;
	logic [VA-1:0] scaledIdx;
	logic [VA-1:0] braSum;

	// SR.JQ sampled, used by next cycle's branch
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			jqFlag <= 1'b0;
		end else begin
			jqFlag <= srJq;
		end
	end

	// index scaled by access size
	assign scaledIdx = regValRt[VA-1:0] << cmdBus.ixt[5:4];
	assign memAddr = regValRs[VA-1:0] + scaledIdx;

	// displacement in 16-bit units
	assign braSum = regValPc[VA-1:0] + {regValRt[VA-2:0], 1'b0};

	always_comb begin
		braTarget = braSum;
		// without JQ the branch stays in the PC's quadrant
		if (!jqFlag) begin
			braTarget[VA-1:32] = regValPc[VA-1:32];
		end
	end

endmodule

`default_nettype wire

// File: ex1BranchUnit.sv
// branch unit: resolves branches against the prediction, selects target, writes LR
`default_nettype none

module ex1BranchUnit (
	ex1CmdIf.sink cmdBus,
	input ex1IsaPkg::regIdT regIdRs,
	input logic [ex1MachPkg::XLEN-1:0] regValRs,
	input logic [ex1MachPkg::XLEN-1:0] regValPc,
	input logic [ex1MachPkg::XLEN-1:0] regInLr,
	input logic [1:0] opPreBra,
	input logic [ex1MachPkg::VALEN-1:0] braTarget,
	output logic doBra,
	output logic [ex1MachPkg::XLEN-1:0] braVal,
	output logic [ex1MachPkg::XLEN-1:0] regOutLr
);

	// prediction codes: 0 not taken, 1 taken
	logic predNotTaken;
	logic predTaken;

	assign predNotTaken = (opPreBra == 2'b00);
	assign predTaken = (opPreBra == 2'b01);

	always_comb begin
		doBra = 1'b0;
		braVal = {regValPc[63:48], braTarget};
		regOutLr = regInLr;

		case (cmdBus.cmd)
			// predicted taken but not taken, go back to the fall-through PC
			ex1IsaPkg::UCMD_BRA_NB: begin
				braVal = regValPc;
				doBra = !predNotTaken;
			end
			ex1IsaPkg::UCMD_BRA: begin
				doBra = !predTaken;
			end
			ex1IsaPkg::UCMD_BSR: begin
				doBra = !predTaken;
				regOutLr = regValPc;
			end
			ex1IsaPkg::UCMD_JMP: begin
				braVal = {regValPc[63:48], regValRs[47:0]};
				// LR and DHR hold full 64-bit return addresses
				if ((regIdRs == ex1IsaPkg::REG_LR) || (regIdRs == ex1IsaPkg::REG_DHR)) begin
					braVal[63:48] = regValRs[63:48];
				end
				doBra = !predTaken;
			end
			// register call is never predicted
			ex1IsaPkg::UCMD_JSR: begin
				braVal = {regValPc[63:48], regValRs[47:0]};
				doBra = 1'b1;
				regOutLr = regValPc;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: ex1SysUnit.sv
// system unit: SR flag ops, trap codes and stall causes
`default_nettype none

module ex1SysUnit (
	ex1CmdIf.sink cmdBus,
	input logic [ex1MachPkg::XLEN-1:0] regInSr,
	input logic [ex1MachPkg::XLEN-1:0] regInDlr,
	input logic [15:0] regInExc,
	input logic memStall,
	output logic [ex1MachPkg::XLEN-1:0] regOutSr,
	output logic [15:0] exTrapExc,
	output logic stall
);

	// unhandled op or BREAK, before the memory stall is merged
	logic opStall;

	always_comb begin
		regOutSr = regInSr;
		exTrapExc = '0;
		opStall = 1'b0;

		case (cmdBus.cmd)
			ex1IsaPkg::UCMD_NOP, ex1IsaPkg::UCMD_LEA_MR, ex1IsaPkg::UCMD_MOV_RM,
			ex1IsaPkg::UCMD_MOV_MR, ex1IsaPkg::UCMD_MOV_RC, ex1IsaPkg::UCMD_MOV_CR,
			ex1IsaPkg::UCMD_MOV_IR, ex1IsaPkg::UCMD_BRA_NB, ex1IsaPkg::UCMD_BRA,
			ex1IsaPkg::UCMD_BSR, ex1IsaPkg::UCMD_JMP, ex1IsaPkg::UCMD_JSR,
			ex1IsaPkg::UCMD_ALU3, ex1IsaPkg::UCMD_MUL3: begin
			end

			ex1IsaPkg::UCMD_OP_IXS: begin
				// IXS work is done in the other units
				case (cmdBus.ixt)
					ex1IsaPkg::IXS_NOP, ex1IsaPkg::IXS_MOVT,
					ex1IsaPkg::IXS_MOVNT, ex1IsaPkg::IXS_TRAPB: begin
					end
					default: opStall = 1'b1;
				endcase
			end

			ex1IsaPkg::UCMD_OP_IXT: begin
				case (cmdBus.ixt)
					ex1IsaPkg::IXT_NOP, ex1IsaPkg::IXT_SLEEP: begin
					end
					// debugger may let BREAK through
					ex1IsaPkg::IXT_BREAK: opStall = !regInExc[15];
					ex1IsaPkg::IXT_CLRT: regOutSr[ex1MachPkg::SR_T] = 1'b0;
					ex1IsaPkg::IXT_SETT: regOutSr[ex1MachPkg::SR_T] = 1'b1;
					ex1IsaPkg::IXT_CLRS: regOutSr[ex1MachPkg::SR_S] = 1'b0;
					ex1IsaPkg::IXT_SETS: regOutSr[ex1MachPkg::SR_S] = 1'b1;
					ex1IsaPkg::IXT_NOTT: regOutSr[ex1MachPkg::SR_T] = !regInSr[ex1MachPkg::SR_T];
					ex1IsaPkg::IXT_NOTS: regOutSr[ex1MachPkg::SR_S] = !regInSr[ex1MachPkg::SR_S];
					ex1IsaPkg::IXT_RTE: exTrapExc = ex1MachPkg::TRAP_RTE;
					// trap number from the Rm field
					ex1IsaPkg::IXT_TRAPA: begin
						exTrapExc = {ex1MachPkg::TRAP_TRAPA_BASE, cmdBus.idRm[3:0]};
					end
					// syscall number from DLR
					ex1IsaPkg::IXT_SYSE: begin
						exTrapExc = {ex1MachPkg::TRAP_SYSE_BASE, regInDlr[11:0]};
					end
					default: opStall = 1'b1;
				endcase
			end

			// INVOP and anything the decoder should not emit
			default: opStall = 1'b1;
		endcase
	end

	assign stall = opStall || memStall;

endmodule

`default_nettype wire

// File: ex1MemIssue.sv
// memory issue: starts loads, stores and the trap bus op, flags a held reply
`default_nettype none

module ex1MemIssue (
	ex1CmdIf.sink cmdBus,
	input logic [ex1MachPkg::VALEN-1:0] memAddrIn,
	input logic [ex1MachPkg::XLEN-1:0] regValRm,
	input ex1MachPkg::memOkE memDataOK,
	output logic [ex1MachPkg::VALEN-1:0] memAddr,
	output ex1MachPkg::memOpmE memOpm,
	output logic [ex1MachPkg::XLEN-1:0] memDataOut,
	output logic memStall
);

	// {unsigned, size}
	logic [2:0] sizeBits;

	assign sizeBits = {cmdBus.ixt[2], cmdBus.ixt[5:4]};

	always_comb begin
		memOpm = ex1MachPkg::OPM_READY;
		case (cmdBus.cmd)
			ex1IsaPkg::UCMD_MOV_RM: begin
				memOpm = ex1MachPkg::memOpmE'(ex1MachPkg::OPM_STORE | {2'b00, sizeBits});
			end
			ex1IsaPkg::UCMD_MOV_MR: begin
				memOpm = ex1MachPkg::memOpmE'(ex1MachPkg::OPM_LOAD | {2'b00, sizeBits});
			end
			ex1IsaPkg::UCMD_OP_IXS: begin
				if (cmdBus.ixt == ex1IsaPkg::IXS_TRAPB) begin
					memOpm = ex1MachPkg::OPM_TRAP;
				end
			end
			default: begin
			end
		endcase
	end

	assign memAddr = memAddrIn;
	assign memDataOut = regValRm;
	// EX2 finishes the access, only the issue cycle waits here
	assign memStall = (memOpm != ex1MachPkg::OPM_READY) && (memDataOK == ex1MachPkg::MOK_HOLD);

endmodule

`default_nettype wire

// File: ex1ResultSelect.sv
// result select: destination values, CR write merge, held marking and flush squash
`default_nettype none

module ex1ResultSelect (
	ex1CmdIf.sink cmdBus,
	input logic [ex1MachPkg::XLEN-1:0] regValRs,
	input logic [ex1MachPkg::XLEN-1:0] regValRt,
	input logic [ex1MachPkg::XLEN-1:0] regValCRm,
	input logic [ex1MachPkg::VALEN-1:0] memAddrIn,
	input logic srT,
	input logic doBra,
	input logic [ex1MachPkg::XLEN-1:0] braVal,
	output ex1IsaPkg::regIdT regIdRn1,
	output logic [ex1MachPkg::XLEN-1:0] regValRn1,
	output ex1IsaPkg::regIdT regIdCn1,
	output logic [ex1MachPkg::XLEN-1:0] regValCn1,
	output ex1IsaPkg::regIdT heldIdRn1,
	output logic held
);

	logic rn1Write;
	logic cn1Write;

	always_comb begin
		rn1Write = 1'b1;
		cn1Write = 1'b0;
		held = 1'b0;
		regValRn1 = regValRt;

		case (cmdBus.cmd)
			ex1IsaPkg::UCMD_LEA_MR: regValRn1 = {16'h0000, memAddrIn};
			// shift-in forms build wide constants in pieces
			ex1IsaPkg::UCMD_MOV_IR: begin
				case (cmdBus.ixt[3:0])
					ex1IsaPkg::MOVIR_LDISH8: regValRn1 = {regValRs[55:0], regValRt[7:0]};
					ex1IsaPkg::MOVIR_LDISH16: regValRn1 = {regValRs[47:0], regValRt[15:0]};
					ex1IsaPkg::MOVIR_LDISH32: regValRn1 = {regValRs[31:0], regValRt[31:0]};
					default: regValRn1 = regValRt;
				endcase
			end
			ex1IsaPkg::UCMD_MOV_CR: regValRn1 = regValCRm;
			// GPR copy goes out on both ports
			ex1IsaPkg::UCMD_MOV_RC: begin
				regValRn1 = regValRs;
				cn1Write = 1'b1;
			end
			ex1IsaPkg::UCMD_OP_IXS: begin
				rn1Write = 1'b0;
				if (cmdBus.ixt == ex1IsaPkg::IXS_MOVT) begin
					regValRn1 = {63'd0, srT};
					rn1Write = 1'b1;
				end else if (cmdBus.ixt == ex1IsaPkg::IXS_MOVNT) begin
					regValRn1 = {63'd0, !srT};
					rn1Write = 1'b1;
				end
			end
			// result arrives in a later stage
			ex1IsaPkg::UCMD_MOV_MR, ex1IsaPkg::UCMD_ALU3, ex1IsaPkg::UCMD_MUL3: begin
				rn1Write = 1'b0;
				held = 1'b1;
			end
			default: rn1Write = 1'b0;
		endcase
	end

	assign regValCn1 = doBra ? braVal : regValRs;

	always_comb begin
		regIdRn1 = rn1Write ? cmdBus.idRm : ex1IsaPkg::REG_ZZR;
		regIdCn1 = ex1IsaPkg::REG_ZZR;
		if (doBra) begin
			regIdCn1 = ex1IsaPkg::CREG_PC;
		end else if (cn1Write) begin
			regIdCn1 = cmdBus.idRm;
		end
		// nothing retires from a flushed slot
		if (cmdBus.flush) begin
			regIdRn1 = ex1IsaPkg::REG_ZZR;
			regIdCn1 = ex1IsaPkg::REG_ZZR;
		end
	end

	assign heldIdRn1 = held ? cmdBus.idRm : ex1IsaPkg::REG_ZZR;

endmodule

`default_nettype wire

// File: ex1Stage.sv
// first execute stage top level: predicate, AGU, branch, system, memory issue and result units
`default_nettype none

module ex1Stage (
	input logic clock,
	input logic arstN,
	input logic [8:0] opUCmd,
	input logic [8:0] opUIxt,
	input logic opBraFlush,
	input logic [1:0] opPreBra,
	input ex1IsaPkg::regIdT regIdRs,
	input ex1IsaPkg::regIdT regIdRm,
	input logic [ex1MachPkg::XLEN-1:0] regValRs,
	input logic [ex1MachPkg::XLEN-1:0] regValRt,
	input logic [ex1MachPkg::XLEN-1:0] regValRm,
	input logic [ex1MachPkg::XLEN-1:0] regValCRm,
	input logic [ex1MachPkg::XLEN-1:0] regValPc,
	input logic [ex1MachPkg::XLEN-1:0] regInSr,
	input logic [ex1MachPkg::XLEN-1:0] regInLr,
	input logic [ex1MachPkg::XLEN-1:0] regInDlr,
	input logic [15:0] regInExc,
	input ex1MachPkg::memOkE memDataOK,
	output logic [1:0] exHold,
	output logic [15:0] exTrapExc,
	output logic [8:0] opUCmdOut,
	output ex1IsaPkg::regIdT regIdRn1,
	output logic [ex1MachPkg::XLEN-1:0] regValRn1,
	output ex1IsaPkg::regIdT regIdCn1,
	output logic [ex1MachPkg::XLEN-1:0] regValCn1,
	output ex1IsaPkg::regIdT heldIdRn1,
	output logic [ex1MachPkg::XLEN-1:0] regOutLr,
	output logic [ex1MachPkg::XLEN-1:0] regOutSr,
	output logic [ex1MachPkg::VALEN-1:0] memAddr,
	output ex1MachPkg::memOpmE memOpm,
	output logic [ex1MachPkg::XLEN-1:0] memDataOut
);

	logic [ex1MachPkg::VALEN-1:0] aguAddr;
	logic [ex1MachPkg::VALEN-1:0] braTarget;
	logic [ex1MachPkg::XLEN-1:0] braVal;
	logic doBra;
	logic memStall;

	ex1CmdIf cmdBus ();

	// opUIxt[8:6] reserved
	ex1Predicate uPred (
		.opUCmd(opUCmd), .opUIxt(opUIxt[5:0]), .regIdRm(regIdRm),
		.opBraFlush(opBraFlush), .srT(regInSr[ex1MachPkg::SR_T]),
		.cmdBus(cmdBus.source), .opUCmdOut(opUCmdOut)
	);

	ex1Agu uAgu (
		.clock(clock), .arstN(arstN), .cmdBus(cmdBus.sink),
		.regValRs(regValRs), .regValRt(regValRt), .regValPc(regValPc),
		.srJq(regInSr[ex1MachPkg::SR_JQ]), .memAddr(aguAddr), .braTarget(braTarget)
	);

	ex1BranchUnit uBra (
		.cmdBus(cmdBus.sink), .regIdRs(regIdRs), .regValRs(regValRs),
		.regValPc(regValPc), .regInLr(regInLr), .opPreBra(opPreBra),
		.braTarget(braTarget), .doBra(doBra), .braVal(braVal), .regOutLr(regOutLr)
	);

	// exHold[0] is the stall level
	ex1SysUnit uSys (
		.cmdBus(cmdBus.sink), .regInSr(regInSr), .regInDlr(regInDlr),
		.regInExc(regInExc), .memStall(memStall), .regOutSr(regOutSr),
		.exTrapExc(exTrapExc), .stall(exHold[0])
	);

	ex1MemIssue uMem (
		.cmdBus(cmdBus.sink), .memAddrIn(aguAddr), .regValRm(regValRm),
		.memDataOK(memDataOK), .memAddr(memAddr), .memOpm(memOpm),
		.memDataOut(memDataOut), .memStall(memStall)
	);

	// exHold[1] marks a held destination
	ex1ResultSelect uRes (
		.cmdBus(cmdBus.sink), .regValRs(regValRs), .regValRt(regValRt),
		.regValCRm(regValCRm), .memAddrIn(aguAddr), .srT(regInSr[ex1MachPkg::SR_T]),
		.doBra(doBra), .braVal(braVal), .regIdRn1(regIdRn1), .regValRn1(regValRn1),
		.regIdCn1(regIdCn1), .regValCn1(regValCn1), .heldIdRn1(heldIdRn1),
		.held(exHold[1])
	);

endmodule

`default_nettype wire

// File: ex1Stage_sva.sv
// assertions for the first execute stage: flush squash, bus op and trap code rules
`default_nettype none

module ex1StageSva (
	input logic clock,
	input logic arstN,
	input logic opBraFlush,
	input logic [8:0] opUIxt,
	input logic [8:0] opUCmdOut,
	input ex1IsaPkg::regIdT regIdRn1,
	input ex1MachPkg::memOpmE memOpm,
	input logic [15:0] exTrapExc
);
	timeunit 1ns;
	timeprecision 100ps;

	logic isMemOp;

	// loads, stores and TRAPB go to the bus
	assign isMemOp = (opUCmdOut[5:0] == ex1IsaPkg::UCMD_MOV_RM)
		|| (opUCmdOut[5:0] == ex1IsaPkg::UCMD_MOV_MR)
		|| ((opUCmdOut[5:0] == ex1IsaPkg::UCMD_OP_IXS)
		&& (opUIxt[5:0] == ex1IsaPkg::IXS_TRAPB));

	squashOnFlush: assert property (@(posedge clock) disable iff (!arstN)
		opBraFlush |-> (regIdRn1 == ex1IsaPkg::REG_ZZR))
		else $error("Rn1 ID not squashed under flush");

	busOpOnlyForMem: assert property (@(posedge clock) disable iff (!arstN)
		!isMemOp |-> (memOpm == ex1MachPkg::OPM_READY))
		else $error("bus op issued for a non-memory op");

	// trap ops never touch the bus
	trapWithoutBus: assert property (@(posedge clock) disable iff (!arstN)
		(exTrapExc != 16'h0000) |-> (memOpm == ex1MachPkg::OPM_READY))
		else $error("trap code raised together with a bus op");

endmodule

bind ex1Stage ex1StageSva sva (
	.clock(clock), .arstN(arstN), .opBraFlush(opBraFlush), .opUIxt(opUIxt),
	.opUCmdOut(opUCmdOut), .regIdRn1(regIdRn1), .memOpm(memOpm), .exTrapExc(exTrapExc)
);

`default_nettype wire

// File: ex1StageTb.sv
// testbench for the first execute stage with random micro-ops checked against a reference model
`default_nettype none

module ex1StageTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int TEST_LEN [NUM_TESTS] = '{400, 300, 300, 200, 300, 200};
	localparam int TOTAL_CYCLES = TEST_LEN[0] + TEST_LEN[1] + TEST_LEN[2] + TEST_LEN[3]
		+ TEST_LEN[4] + TEST_LEN[5];
	localparam int WATCHDOG_NS = (RESET_CYCLES + TOTAL_CYCLES + 100) * PERIOD;

	logic clock;
	logic arstN;
	logic [8:0] opUCmd, opUIxt;
	logic opBraFlush;
	logic [1:0] opPreBra;
	ex1IsaPkg::regIdT regIdRs, regIdRm;
	logic [63:0] regValRs, regValRt, regValRm, regValCRm, regValPc;
	logic [63:0] regInSr, regInLr, regInDlr;
	logic [15:0] regInExc;
	ex1MachPkg::memOkE memDataOK;
	// DUT outputs
	logic [1:0] exHold;
	logic [15:0] exTrapExc;
	logic [8:0] opUCmdOut;
	ex1IsaPkg::regIdT regIdRn1, regIdCn1, heldIdRn1;
	logic [63:0] regValRn1, regValCn1, regOutLr, regOutSr, memDataOut;
	logic [47:0] memAddr;
	ex1MachPkg::memOpmE memOpm;

	logic [31:0] rngState;
	// model copy of the jump-quadrant flag
	logic modelJq;
	int errCount;
	int checkCount;

	ex1Stage DUT (.*);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// xorshift32
	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkVal64(input logic [63:0] got, input logic [63:0] exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkVal16(input logic [15:0] got, input logic [15:0] exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkId(input ex1IsaPkg::regIdT got, input ex1IsaPkg::regIdT exp,
			input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCmd(input ex1IsaPkg::uCmdE got, input ex1IsaPkg::uCmdE exp,
			input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkOpm(input ex1MachPkg::memOpmE got, input ex1MachPkg::memOpmE exp,
			input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// random data everywhere with the op mix chosen by the test kind
	task automatic makeStimulus(input int kind);
		logic [31:0] r;
		logic [5:0] cmd;
		logic [5:0] ixt;
		logic [1:0] cond;
		r = nextRand();
		cond = 2'b00;
		cmd = ex1IsaPkg::UCMD_NOP;
		ixt = 6'(nextRand());
		opBraFlush = 1'b0;
		regValRs = {nextRand(), nextRand()};
		regValRt = {nextRand(), nextRand()};
		regValRm = {nextRand(), nextRand()};
		regValCRm = {nextRand(), nextRand()};
		regValPc = {nextRand(), nextRand()};
		regInSr = {nextRand(), nextRand()};
		regInLr = {nextRand(), nextRand()};
		regInDlr = {nextRand(), nextRand()};
		regInExc = 16'(nextRand());
		regIdRs = 6'(nextRand());
		regIdRm = 6'(nextRand());
		opPreBra = 2'(nextRand());
		memDataOK = ex1MachPkg::memOkE'(2'(nextRand() % 3));
		case (kind)
			// any op including unknown codes 17..19
			1: begin
				cmd = 6'(r % 20);
				cond = 2'(r >> 8);
				opBraFlush = (r[13:12] == 2'b00);
			end
			2: begin
				case (r % 6)
					0: cmd = ex1IsaPkg::UCMD_LEA_MR;
					1: cmd = ex1IsaPkg::UCMD_MOV_RC;
					2: cmd = ex1IsaPkg::UCMD_MOV_CR;
					3: begin
						cmd = ex1IsaPkg::UCMD_OP_IXS;
						ixt = 6'(1 + r[8]);
					end
					default: begin
						cmd = ex1IsaPkg::UCMD_MOV_IR;
						ixt[3:0] = 4'((r >> 8) % 5);
					end
				endcase
			end
			3: begin
				case (r % 5)
					0: cmd = ex1IsaPkg::UCMD_BRA_NB;
					1: cmd = ex1IsaPkg::UCMD_BRA;
					2: cmd = ex1IsaPkg::UCMD_BSR;
					3: cmd = ex1IsaPkg::UCMD_JMP;
					default: cmd = ex1IsaPkg::UCMD_JSR;
				endcase
				cond = 2'(r >> 8);
				// LR and DHR often since they keep the upper address bits
				if (r[11:10] == 2'b00) begin
					regIdRs = ex1IsaPkg::REG_LR;
				end else if (r[11:10] == 2'b01) begin
					regIdRs = ex1IsaPkg::REG_DHR;
				end
			end
			// flag ops and traps from CLRT up to SYSE
			4: begin
				cmd = ex1IsaPkg::UCMD_OP_IXT;
				ixt = 6'(3 + (r >> 8) % 9);
			end
			5: begin
				case (r % 3)
					0: cmd = ex1IsaPkg::UCMD_MOV_RM;
					1: cmd = ex1IsaPkg::UCMD_MOV_MR;
					default: begin
						cmd = ex1IsaPkg::UCMD_OP_IXS;
						ixt = ex1IsaPkg::IXS_TRAPB;
					end
				endcase
			end
			default: begin
				case (r % 3)
					0: cmd = ex1IsaPkg::UCMD_INVOP;
					1: cmd = ex1IsaPkg::UCMD_OP_IXS;
					default: begin
						cmd = ex1IsaPkg::UCMD_OP_IXT;
						if (r[8]) begin
							ixt = ex1IsaPkg::IXT_BREAK;
						end
					end
				endcase
			end
		endcase
		opUCmd = {1'b0, cond, cmd};
		opUIxt = {3'b000, ixt};
	endtask

	// reference model of every output followed by the compares
	task automatic checkOutputs();
		logic [5:0] raw, eff, ixt;
		logic [1:0] cond;
		logic t, en, db, wr, cw, hl, st;
		logic [47:0] addr, bt;
		logic [63:0] bv, lr, sr, rn1v;
		logic [15:0] trap;
		ex1MachPkg::memOpmE opm;
		ex1IsaPkg::regIdT rn1Id, cn1Id;
		raw = opUCmd[5:0];
		cond = opUCmd[7:6];
		ixt = opUIxt[5:0];
		t = regInSr[0];
		// AL 00, NV 01, CT 10, CF 11
		en = ((cond == 2'b00) || (cond == 2'b10 && t) || (cond == 2'b11 && !t)) && !opBraFlush;
		eff = en ? raw : ((raw == ex1IsaPkg::UCMD_BRA && !opBraFlush) ?
			ex1IsaPkg::UCMD_BRA_NB : ex1IsaPkg::UCMD_NOP);

		addr = regValRs[47:0] + (regValRt[47:0] << ixt[5:4]);
		bt = regValPc[47:0] + 48'(regValRt * 2);
		if (!modelJq) begin
			bt[47:32] = regValPc[47:32];
		end

		// branch decision with prediction 0 not taken and 1 taken
		db = 1'b0;
		bv = {regValPc[63:48], bt};
		lr = regInLr;
		case (eff)
			ex1IsaPkg::UCMD_BRA_NB: begin
				db = (opPreBra != 2'd0);
				bv = regValPc;
			end
			ex1IsaPkg::UCMD_BRA, ex1IsaPkg::UCMD_BSR: db = (opPreBra != 2'd1);
			ex1IsaPkg::UCMD_JMP: begin
				db = (opPreBra != 2'd1);
				bv[47:0] = regValRs[47:0];
				if (regIdRs == ex1IsaPkg::REG_LR || regIdRs == ex1IsaPkg::REG_DHR) begin
					bv[63:48] = regValRs[63:48];
				end
			end
			ex1IsaPkg::UCMD_JSR: begin
				db = 1'b1;
				bv[47:0] = regValRs[47:0];
			end
			default: begin
			end
		endcase
		if (eff == ex1IsaPkg::UCMD_BSR || eff == ex1IsaPkg::UCMD_JSR) begin
			lr = regValPc;
		end

		// SR ops, traps and op stalls
		sr = regInSr;
		trap = 16'h0000;
		st = (eff == ex1IsaPkg::UCMD_INVOP) || (eff > ex1IsaPkg::UCMD_OP_IXT);
		if (eff == ex1IsaPkg::UCMD_OP_IXS) begin
			st = (ixt > ex1IsaPkg::IXS_TRAPB);
		end
		if (eff == ex1IsaPkg::UCMD_OP_IXT) begin
			case (ixt)
				ex1IsaPkg::IXT_BREAK: st = !regInExc[15];
				ex1IsaPkg::IXT_CLRT: sr[0] = 1'b0;
				ex1IsaPkg::IXT_SETT: sr[0] = 1'b1;
				ex1IsaPkg::IXT_CLRS: sr[1] = 1'b0;
				ex1IsaPkg::IXT_SETS: sr[1] = 1'b1;
				ex1IsaPkg::IXT_NOTT: sr[0] = !regInSr[0];
				ex1IsaPkg::IXT_NOTS: sr[1] = !regInSr[1];
				ex1IsaPkg::IXT_RTE: trap = 16'hFF00;
				ex1IsaPkg::IXT_TRAPA: trap = {12'hC08, regIdRm[3:0]};
				ex1IsaPkg::IXT_SYSE: trap = {4'hE, regInDlr[11:0]};
				default: st = (ixt > ex1IsaPkg::IXT_SYSE);
			endcase
		end

		// bus op {kind, unsigned, size}
		opm = ex1MachPkg::OPM_READY;
		if (eff == ex1IsaPkg::UCMD_MOV_RM) begin
			opm = ex1MachPkg::memOpmE'({2'b10, ixt[2], ixt[5:4]});
		end
		if (eff == ex1IsaPkg::UCMD_MOV_MR) begin
			opm = ex1MachPkg::memOpmE'({2'b01, ixt[2], ixt[5:4]});
		end
		if (eff == ex1IsaPkg::UCMD_OP_IXS && ixt == ex1IsaPkg::IXS_TRAPB) begin
			opm = ex1MachPkg::OPM_TRAP;
		end
		st = st || ((opm != ex1MachPkg::OPM_READY) && (memDataOK == ex1MachPkg::MOK_HOLD));

		// destination writes
		rn1v = regValRt;
		wr = 1'b1;
		cw = 1'b0;
		hl = 1'b0;
		case (eff)
			ex1IsaPkg::UCMD_LEA_MR: rn1v = {16'h0000, addr};
			ex1IsaPkg::UCMD_MOV_IR: begin
				case (ixt[3:0])
					4'd1: rn1v = (regValRs << 8) | (regValRt & 64'hFF);
					4'd2: rn1v = (regValRs << 16) | (regValRt & 64'hFFFF);
					4'd3: rn1v = (regValRs << 32) | (regValRt & 64'hFFFF_FFFF);
					default: rn1v = regValRt;
				endcase
			end
			ex1IsaPkg::UCMD_MOV_CR: rn1v = regValCRm;
			ex1IsaPkg::UCMD_MOV_RC: begin
				rn1v = regValRs;
				cw = 1'b1;
			end
			ex1IsaPkg::UCMD_OP_IXS: begin
				wr = (ixt == ex1IsaPkg::IXS_MOVT) || (ixt == ex1IsaPkg::IXS_MOVNT);
				rn1v = (ixt == ex1IsaPkg::IXS_MOVT) ? 64'(t) : 64'(!t);
			end
			ex1IsaPkg::UCMD_MOV_MR, ex1IsaPkg::UCMD_ALU3, ex1IsaPkg::UCMD_MUL3: begin
				wr = 1'b0;
				hl = 1'b1;
			end
			default: wr = 1'b0;
		endcase
		rn1Id = (wr && !opBraFlush) ? regIdRm : ex1IsaPkg::REG_ZZR;
		cn1Id = db ? ex1IsaPkg::CREG_PC : (cw ? regIdRm : ex1IsaPkg::REG_ZZR);
		if (opBraFlush) begin
			cn1Id = ex1IsaPkg::REG_ZZR;
		end

		checkCmd(ex1IsaPkg::uCmdE'(opUCmdOut[5:0]), ex1IsaPkg::uCmdE'(eff), "effective cmd");
		checkVal16(16'(opUCmdOut[8:6]), 16'h0000, "cmd condition bits");
		checkId(regIdRn1, rn1Id, "Rn1 ID");
		if (wr) begin
			checkVal64(regValRn1, rn1v, "Rn1 value");
		end
		checkId(regIdCn1, cn1Id, "Cn1 ID");
		if (db || cw) begin
			checkVal64(regValCn1, db ? bv : regValRs, "Cn1 value");
		end
		checkId(heldIdRn1, hl ? regIdRm : ex1IsaPkg::REG_ZZR, "held ID");
		checkVal64(regOutLr, lr, "LR");
		checkVal64(regOutSr, sr, "SR");
		checkVal64(64'(memAddr), 64'(addr), "memory address");
		checkOpm(memOpm, opm, "bus op");
		checkVal64(memDataOut, regValRm, "store data");
		checkVal16(exTrapExc, trap, "trap code");
		checkVal16({14'd0, exHold}, {14'd0, hl, st}, "exHold");
	endtask

	// drive on the falling edge and compare a quarter period later
	task automatic runTest(input int kind, input string name);
		int startErr;
		startErr = errCount;
		repeat (TEST_LEN[kind - 1]) begin
			@(negedge clock);
			makeStimulus(kind);
			#(PERIOD / 4);
			checkOutputs();
			// next rising edge captures SR.JQ
			modelJq = regInSr[31];
		end
		$display("test %0d %s: %0d cycles, %0d errors", kind, name, TEST_LEN[kind - 1],
			errCount - startErr);
	endtask

	initial begin
		rngState = 32'h292d7312;
		modelJq = 1'b0;
		errCount = 0;
		checkCount = 0;
		arstN = 1'b0;
		opUCmd = '0;
		opUIxt = '0;
		opBraFlush = 1'b0;
		opPreBra = '0;
		regIdRs = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValCRm = '0;
		regValPc = '0;
		regInSr = '0;
		regInLr = '0;
		regInDlr = '0;
		regInExc = '0;
		memDataOK = ex1MachPkg::MOK_READY;
		repeat (RESET_CYCLES) @(negedge clock);
		arstN = 1'b1;
		runTest(1, "predication");
		runTest(2, "moves");
		runTest(3, "branches");
		runTest(4, "SR and traps");
		runTest(5, "memory issue");
		runTest(6, "stall causes");
		$display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errCount);
		if (errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: ex1Stage.f
ex1IsaPkg.sv
ex1MachPkg.sv
ex1CmdIf.sv
ex1Predicate.sv
ex1Agu.sv
ex1BranchUnit.sv
ex1SysUnit.sv
ex1MemIssue.sv
ex1ResultSelect.sv
ex1Stage.sv
ex1Stage_sva.sv
ex1StageTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = ex1StageTb
FILELIST = ex1Stage.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# the log decides the result, a run that stops early has no pass line
run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -qF '*** FAILED ***' $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
